// File: axis_width_converter.f
design/axis_pkg.sv
design/meta_pkg.sv
design/sync_fifo.sv
design/pkt_length_counter.sv
design/lane_select.sv
design/downsize_ctrl.sv
design/axis_width_converter.sv
testbench/tb_axis_width_converter.sv

// File: design/axis_pkg.sv
//////////////////////////////////////////////////
// Stream width defaults for the width converter
// Packet size limit and FIFO sizing constants
//////////////////////////////////////////////////

package axis_pkg;

   //////////////////////////////////////////////////
   // Stream widths

   localparam int S_DATA_WIDTH_DEF = 256;    // Slave word, 32 bytes
   localparam int M_DATA_WIDTH_DEF = 64;     // Master word, 8 bytes

   //////////////////////////////////////////////////
   // Packet buffering

   // Largest packet in bytes
   localparam int MAX_PKT_BYTES = 1600;

   // 64 entries hold a full 1600 byte packet at 32 bytes per word
   localparam int PKT_FIFO_DEPTH_BITS = 6;

   localparam int LEN_FIFO_DEPTH_BITS = 5;  // Up to 32 queued lengths

   // Free entries left when nearly_full rises
   // Covers words accepted while the registered ready catches up
   localparam int NEARLY_FULL_MARGIN = 4;

endpackage

// File: design/axis_width_converter.sv
//////////////////////////////////////////////////
// Width-down AXI4-Stream converter, top level
// Packet buffer, length counter, lane selector,
// control and tuser metadata build
//////////////////////////////////////////////////

`timescale 1ns/10ps

module axis_width_converter #(
   parameter int S_DATA_WIDTH = axis_pkg::S_DATA_WIDTH_DEF,
   parameter int M_DATA_WIDTH = axis_pkg::M_DATA_WIDTH_DEF
) (
   input  logic                             axi_aclk,
   input  logic                             axi_resetn,
   // Slave stream
   input  logic [S_DATA_WIDTH-1:0]          s_axis_tdata,
   input  logic [S_DATA_WIDTH/8-1:0]        s_axis_tstrb,
   input  logic                             s_axis_tlast,
   input  logic                             s_axis_tvalid,
   output logic                             s_axis_tready,
   // Master stream
   output logic [M_DATA_WIDTH-1:0]          m_axis_tdata,
   output logic [M_DATA_WIDTH/8-1:0]        m_axis_tstrb,
   output logic [meta_pkg::TUSER_WIDTH-1:0] m_axis_tuser,
   output logic                             m_axis_tlast,
   output logic                             m_axis_tvalid,
   input  logic                             m_axis_tready
);

   import axis_pkg::*;
   import meta_pkg::*;

   localparam int S_BYTES   = S_DATA_WIDTH / 8;
   localparam int LANE_BITS = $clog2(S_DATA_WIDTH / M_DATA_WIDTH);
   localparam int PKT_WIDTH = S_DATA_WIDTH + S_BYTES + 1;   // last, strb, data

   logic                    accept;
   logic                    pkt_empty;
   logic                    pkt_nearly_full;
   logic                    pkt_rd_en;
   logic [S_DATA_WIDTH-1:0] head_data;
   logic [S_BYTES-1:0]      head_strb;
   logic                    head_last;
   logic [LEN_WIDTH-1:0]    len_head;
   logic                    len_empty;
   logic                    len_nearly_full;
   logic                    len_rd_en;
   logic [LANE_BITS-1:0]    lane_idx;
   logic                    next_lane_empty;
   logic                    sop;             // Next master beat starts a packet

   assign accept = s_axis_tvalid & s_axis_tready;

   // Ready lags the FIFO flags by one cycle, the margin absorbs the overrun
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         s_axis_tready <= 1'b0;
      end else begin
         s_axis_tready <= ~pkt_nearly_full & ~len_nearly_full;
      end
   end

   //////////////////////////////////////////////////
   // Buffering

   sync_fifo #(
      .WIDTH      (PKT_WIDTH),
      .DEPTH_BITS (PKT_FIFO_DEPTH_BITS)
   ) pkt_fifo_inst (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .din         ({s_axis_tlast, s_axis_tstrb, s_axis_tdata}),
      .wr_en       (accept),
      .rd_en       (pkt_rd_en),
      .dout        ({head_last, head_strb, head_data}),
      .empty       (pkt_empty),
      .full        (),
      .nearly_full (pkt_nearly_full)
   );

   pkt_length_counter #(
      .S_DATA_WIDTH (S_DATA_WIDTH)
   ) pkt_length_counter_inst (
      .axi_aclk        (axi_aclk),
      .axi_resetn      (axi_resetn),
      .s_axis_tstrb    (s_axis_tstrb),
      .s_axis_tlast    (s_axis_tlast),
      .accept          (accept),
      .len_rd_en       (len_rd_en),
      .len_head        (len_head),
      .len_empty       (len_empty),
      .len_nearly_full (len_nearly_full)
   );

   //////////////////////////////////////////////////
   // Output side

   lane_select #(
      .S_DATA_WIDTH (S_DATA_WIDTH),
      .M_DATA_WIDTH (M_DATA_WIDTH)
   ) lane_select_inst (
      .head_data       (head_data),
      .head_strb       (head_strb),
      .lane_idx        (lane_idx),
      .lane_data       (m_axis_tdata),
      .lane_strb       (m_axis_tstrb),
      .next_lane_empty (next_lane_empty)
   );

   downsize_ctrl #(
      .S_DATA_WIDTH (S_DATA_WIDTH),
      .M_DATA_WIDTH (M_DATA_WIDTH)
   ) downsize_ctrl_inst (
      .axi_aclk        (axi_aclk),
      .axi_resetn      (axi_resetn),
      .pkt_empty       (pkt_empty),
      .head_last       (head_last),
      .len_empty       (len_empty),
      .next_lane_empty (next_lane_empty),
      .m_axis_tready   (m_axis_tready),
      .lane_idx        (lane_idx),
      .pkt_rd_en       (pkt_rd_en),
      .len_rd_en       (len_rd_en),
      .m_axis_tvalid   (m_axis_tvalid),
      .m_axis_tlast    (m_axis_tlast)
   );

   // Track packet starts on the master side for tuser
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         sop <= 1'b1;
      end else if (m_axis_tvalid && m_axis_tready) begin
         sop <= m_axis_tlast;
      end
   end

   // Metadata only on the first beat, zero elsewhere
   always_comb begin
      m_axis_tuser = '0;
      if (sop) begin
         m_axis_tuser[LEN_LSB +: LEN_WIDTH] = len_head;
         m_axis_tuser[SPT_LSB +: SPT_WIDTH] = DEFAULT_SRC_PORT;
         m_axis_tuser[DPT_LSB +: DPT_WIDTH] = DEFAULT_DST_PORT;
         m_axis_tuser[TUSER_WIDTH-1:PAD_LSB] = '0;
      end
   end

endmodule

// File: design/downsize_ctrl.sv
//////////////////////////////////////////////////
// Downsizing control
// Walks the lanes of each buffered word, pops the
// packet and length FIFOs, drives master valid/last
//////////////////////////////////////////////////

`timescale 1ns/10ps

module downsize_ctrl #(
   parameter int S_DATA_WIDTH = axis_pkg::S_DATA_WIDTH_DEF,
   parameter int M_DATA_WIDTH = axis_pkg::M_DATA_WIDTH_DEF
) (
   input  logic                                          axi_aclk,
   input  logic                                          axi_resetn,
   input  logic                                          pkt_empty,
   input  logic                                          head_last,
   input  logic                                          len_empty,
   input  logic                                          next_lane_empty,
   input  logic                                          m_axis_tready,
   output logic [$clog2(S_DATA_WIDTH/M_DATA_WIDTH)-1:0]  lane_idx,
   output logic                                          pkt_rd_en,
   output logic                                          len_rd_en,
   output logic                                          m_axis_tvalid,
   output logic                                          m_axis_tlast
);

   localparam int RATIO     = S_DATA_WIDTH / M_DATA_WIDTH;
   localparam int LANE_BITS = $clog2(RATIO);

   logic first_beat;   // Next beat opens a packet
   logic top_lane;
   logic word_done;    // Current beat finishes the buffered word
   logic m_xfer;

   //////////////////////////////////////////////////
   // Beat decode

   assign top_lane = (lane_idx == LANE_BITS'(RATIO - 1));

   // First beat also needs the length, later beats only data
   assign m_axis_tvalid = ~pkt_empty & (~first_beat | ~len_empty);

   // Early end when the final word has no bytes past this lane
   assign m_axis_tlast = head_last & next_lane_empty;
   assign word_done    = top_lane | m_axis_tlast;

   assign m_xfer    = m_axis_tvalid & m_axis_tready;
   assign pkt_rd_en = m_xfer & word_done;
   assign len_rd_en = m_xfer & first_beat;   // Length leaves with the first beat

   //////////////////////////////////////////////////
   // State, advances only on master transfers

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         lane_idx   <= '0;
         first_beat <= 1'b1;
      end else if (m_xfer) begin
         lane_idx   <= word_done ? '0 : lane_idx + 1'b1;
         first_beat <= m_axis_tlast;
      end
   end

   // Held beat must not move until the sink takes it
   a_hold_stall : assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      (m_axis_tvalid && !m_axis_tready) |=>
         (m_axis_tvalid && $stable(m_axis_tlast) && $stable(lane_idx)))
      else $error("master beat changed under back-pressure");

endmodule

// File: design/lane_select.sv
//////////////////////////////////////////////////
// Lane selector for the buffered slave word
// Current master lane and empty-next-lane flag
//////////////////////////////////////////////////

`timescale 1ns/10ps

module lane_select #(
   parameter int S_DATA_WIDTH = axis_pkg::S_DATA_WIDTH_DEF,
   parameter int M_DATA_WIDTH = axis_pkg::M_DATA_WIDTH_DEF
) (
   input  logic [S_DATA_WIDTH-1:0]                       head_data,
   input  logic [S_DATA_WIDTH/8-1:0]                     head_strb,
   input  logic [$clog2(S_DATA_WIDTH/M_DATA_WIDTH)-1:0]  lane_idx,
   output logic [M_DATA_WIDTH-1:0]                       lane_data,
   output logic [M_DATA_WIDTH/8-1:0]                     lane_strb,
   output logic                                          next_lane_empty
);

   localparam int RATIO     = S_DATA_WIDTH / M_DATA_WIDTH;
   localparam int LANE_BITS = $clog2(RATIO);
   localparam int M_BYTES   = M_DATA_WIDTH / 8;

   logic [LANE_BITS-1:0] next_idx;
   logic                 top_lane;

   assign next_idx = lane_idx + 1'b1;   // Wraps at the top lane
   assign top_lane = (lane_idx == LANE_BITS'(RATIO - 1));

   // Lane 0 is the least significant slice
   assign lane_data = head_data[lane_idx*M_DATA_WIDTH +: M_DATA_WIDTH];
   assign lane_strb = head_strb[lane_idx*M_BYTES +: M_BYTES];

   // Nothing left in this word after the current lane
   assign next_lane_empty = top_lane | ~|head_strb[next_idx*M_BYTES +: M_BYTES];

endmodule

// File: design/meta_pkg.sv
//////////////////////////////////////////////////
// Metadata word carried on the master tuser
// Field widths, bit positions and default ports
//////////////////////////////////////////////////

package meta_pkg;

   //////////////////////////////////////////////////
   // Field widths

   localparam int LEN_WIDTH   = 16;          // Byte length
   localparam int SPT_WIDTH   = 8;           // Source port
   localparam int DPT_WIDTH   = 8;           // Destination port
   localparam int TUSER_WIDTH = 128;

   //////////////////////////////////////////////////
   // Layout from bit 0 upward
   // Length first, then source and destination port, zero padding on top

   localparam int LEN_LSB = 0;
   localparam int SPT_LSB = LEN_LSB + LEN_WIDTH;
   localparam int DPT_LSB = SPT_LSB + SPT_WIDTH;
   localparam int PAD_LSB = DPT_LSB + DPT_WIDTH;   // 96 zero bits from here

   //////////////////////////////////////////////////
   // Default port values

   localparam logic [SPT_WIDTH-1:0] DEFAULT_SRC_PORT = 8'h01;
   localparam logic [DPT_WIDTH-1:0] DEFAULT_DST_PORT = 8'h04;

endpackage

// File: design/pkt_length_counter.sv
//////////////////////////////////////////////////
// Per-packet byte counter
// Sums strobes of accepted words, queues each total
//////////////////////////////////////////////////

`timescale 1ns/10ps

module pkt_length_counter #(
   parameter int S_DATA_WIDTH = axis_pkg::S_DATA_WIDTH_DEF
) (
   input  logic                           axi_aclk,
   input  logic                           axi_resetn,
   input  logic [S_DATA_WIDTH/8-1:0]      s_axis_tstrb,
   input  logic                           s_axis_tlast,
   input  logic                           accept,
   input  logic                           len_rd_en,
   output logic [meta_pkg::LEN_WIDTH-1:0] len_head,
   output logic                           len_empty,
   output logic                           len_nearly_full
);

   import axis_pkg::*;
   import meta_pkg::*;

   localparam int S_BYTES = S_DATA_WIDTH / 8;
   localparam int CNT_W   = $clog2(S_BYTES) + 1;   // Holds 0..S_BYTES

   logic [CNT_W-1:0]     word_bytes;
   logic [LEN_WIDTH-1:0] running_sum;
   logic [LEN_WIDTH-1:0] pkt_len;
   logic                 len_push;

   // Highest set strobe plus one, strobes are contiguous from lane 0
   always_comb begin
      word_bytes = '0;
      for (int i = 0; i < S_BYTES; i++) begin
         if (s_axis_tstrb[i]) word_bytes = CNT_W'(i + 1);
      end
   end

   assign pkt_len  = running_sum + LEN_WIDTH'(word_bytes);
   assign len_push = accept & s_axis_tlast;   // Pushed with the tlast word

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         running_sum <= '0;
      end else if (len_push) begin
         running_sum <= '0;                   // Next packet starts fresh
      end else if (accept) begin
         running_sum <= pkt_len;
      end
   end

   sync_fifo #(
      .WIDTH      (LEN_WIDTH),
      .DEPTH_BITS (LEN_FIFO_DEPTH_BITS)
   ) len_fifo_inst (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .din         (pkt_len),
      .wr_en       (len_push),
      .rd_en       (len_rd_en),
      .dout        (len_head),
      .empty       (len_empty),
      .full        (),
      .nearly_full (len_nearly_full)
   );

   // Packet buffer is sized for this limit
   a_pkt_len_max : assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      len_push |-> (pkt_len <= LEN_WIDTH'(MAX_PKT_BYTES)))
      else $error("packet longer than %0d bytes", MAX_PKT_BYTES);

endmodule

// File: design/sync_fifo.sv
//////////////////////////////////////////////////
// Fall-through synchronous FIFO
// Register array with empty, full and nearly-full flags
//////////////////////////////////////////////////

`timescale 1ns/10ps

module sync_fifo #(
   parameter int WIDTH      = 8,
   parameter int DEPTH_BITS = axis_pkg::LEN_FIFO_DEPTH_BITS
) (
   input  logic             axi_aclk,
   input  logic             axi_resetn,
   input  logic [WIDTH-1:0] din,
   input  logic             wr_en,
   input  logic             rd_en,
   output logic [WIDTH-1:0] dout,
   output logic             empty,
   output logic             full,
   output logic             nearly_full
);

   import axis_pkg::*;

   localparam int DEPTH = 1 << DEPTH_BITS;

   logic [WIDTH-1:0]    mem [DEPTH];
   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;   // One extra bit so a full FIFO is distinct
   logic                  do_wr;
   logic                  do_rd;

   assign do_wr = wr_en & ~full;
   assign do_rd = rd_en & ~empty;

   // Head word shows without a read
   assign dout  = mem[rd_ptr];
   assign empty = (count == '0);
   assign full  = (count == (DEPTH_BITS+1)'(DEPTH));
   // Fewer than NEARLY_FULL_MARGIN entries free
   assign nearly_full = (count > (DEPTH_BITS+1)'(DEPTH - NEARLY_FULL_MARGIN));

   always_ff @(posedge axi_aclk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) wr_ptr <= wr_ptr + 1'b1;
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Both or neither
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Callers must respect the flags

   a_no_write_full : assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      !(wr_en && full))
      else $error("sync_fifo write while full");

   a_no_read_empty : assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      !(rd_en && empty))
      else $error("sync_fifo read while empty");

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the width converter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module tb_axis_width_converter \
   -f axis_width_converter.f \
   -o sim_tb

# The log decides the result, so a stopped run must not end the script here
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi
if ! grep -q "Verification passed" sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi
echo "Simulation done"

// File: testbench/tb_axis_width_converter.sv
//////////////////////////////////////////////////
// Testbench for the width-down stream converter
// Packets from the data file, expected beat model,
// random master stalls, watchdog
//////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_axis_width_converter;

   import axis_pkg::*;
   import meta_pkg::*;

   localparam int S_W        = S_DATA_WIDTH_DEF;
   localparam int M_W        = M_DATA_WIDTH_DEF;
   localparam int S_BYTES    = S_W / 8;
   localparam int M_BYTES    = M_W / 8;
   localparam int CLK_PERIOD = 20;
   localparam int MAX_PKTS   = 32;

   logic                   axi_aclk = 1'b0;
   logic                   axi_resetn;
   logic [S_W-1:0]         s_axis_tdata;
   logic [S_BYTES-1:0]     s_axis_tstrb;
   logic                   s_axis_tlast;
   logic                   s_axis_tvalid;
   logic                   s_axis_tready;
   logic [M_W-1:0]         m_axis_tdata;
   logic [M_BYTES-1:0]     m_axis_tstrb;
   logic [TUSER_WIDTH-1:0] m_axis_tuser;
   logic                   m_axis_tlast;
   logic                   m_axis_tvalid;
   logic                   m_axis_tready;

   logic [15:0]            pkt_table [0:2*MAX_PKTS-1];   // Length, first byte pairs
   int                     num_pkts;
   int                     total_beats;
   int                     beat_count = 0;
   logic                   loaded = 1'b0;
   logic [31:0]            lfsr_state = 32'h47af0a8f;

   logic [M_W-1:0]         exp_data [$];
   logic [M_BYTES-1:0]     exp_strb [$];
   logic                   exp_last [$];
   logic [TUSER_WIDTH-1:0] exp_user [$];

   // Monitor state
   logic                   tlast_sent = 1'b0;
   logic                   ready_was_high = 1'b0;
   logic                   backpressure_seen = 1'b0;
   logic                   held = 1'b0;
   logic [M_W-1:0]         held_data;
   logic [M_BYTES-1:0]     held_strb;
   logic                   held_last;
   logic [TUSER_WIDTH-1:0] held_user;

   axis_width_converter #(
      .S_DATA_WIDTH (S_W),
      .M_DATA_WIDTH (M_W)
   ) axis_width_converter_inst (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .s_axis_tdata  (s_axis_tdata),
      .s_axis_tstrb  (s_axis_tstrb),
      .s_axis_tlast  (s_axis_tlast),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tstrb  (m_axis_tstrb),
      .m_axis_tuser  (m_axis_tuser),
      .m_axis_tlast  (m_axis_tlast),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready)
   );

   always #(CLK_PERIOD/2) axi_aclk = ~axi_aclk;

   //////////////////////////////////////////////////
   // Helpers

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [7:0] pkt_byte(input logic [7:0] first, input int idx);
      return 8'((int'(first) + idx) % 256);
   endfunction

   // Length at bit 0, then source and destination port, zeros above
   function automatic logic [TUSER_WIDTH-1:0] meta_word(input int len);
      return {96'h0, DEFAULT_DST_PORT, DEFAULT_SRC_PORT, 16'(len)};
   endfunction

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Verification failed");
      $fatal(1, "Simulation stopped at first error");
   endtask

   // Re-pack every packet into 8 byte beats
   task automatic build_expected();
      int               len;
      int               n_beats;
      int               idx;
      logic [7:0]       first;
      logic [M_W-1:0]   d;
      logic [M_BYTES-1:0] s;
      total_beats = 0;
      for (int p = 0; p < num_pkts; p++) begin
         len     = int'(pkt_table[2*p]);
         first   = pkt_table[2*p+1][7:0];
         n_beats = (len + M_BYTES - 1) / M_BYTES;
         for (int b = 0; b < n_beats; b++) begin
            d = '0;
            s = '0;
            for (int k = 0; k < M_BYTES; k++) begin
               idx = b * M_BYTES + k;
               if (idx < len) begin
                  d[k*8 +: 8] = pkt_byte(first, idx);
                  s[k]        = 1'b1;
               end
            end
            exp_data.push_back(d);
            exp_strb.push_back(s);
            exp_last.push_back(b == n_beats - 1);
            exp_user.push_back((b == 0) ? meta_word(len) : '0);
         end
         total_beats += n_beats;
      end
   endtask

   task automatic send_packet(input int p);
      int         len;
      int         n_words;
      int         idx;
      logic [7:0] first;
      len     = int'(pkt_table[2*p]);
      first   = pkt_table[2*p+1][7:0];
      n_words = (len + S_BYTES - 1) / S_BYTES;
      for (int w = 0; w < n_words; w++) begin
         @(negedge axi_aclk);
         s_axis_tdata = '0;   // Bytes past the end stay zero
         s_axis_tstrb = '0;
         for (int k = 0; k < S_BYTES; k++) begin
            idx = w * S_BYTES + k;
            if (idx < len) begin
               s_axis_tdata[k*8 +: 8] = pkt_byte(first, idx);
               s_axis_tstrb[k]        = 1'b1;
            end
         end
         s_axis_tlast  = (w == n_words - 1);
         s_axis_tvalid = 1'b1;
         @(posedge axi_aclk);
         while (!s_axis_tready) @(posedge axi_aclk);   // Wait for the accept edge
      end
   endtask

   task automatic check_beat();
      logic [M_W-1:0]         e_data;
      logic [M_BYTES-1:0]     e_strb;
      logic                   e_last;
      logic [TUSER_WIDTH-1:0] e_user;
      if (exp_data.size() > 0) begin
         e_data = exp_data.pop_front();
         e_strb = exp_strb.pop_front();
         e_last = exp_last.pop_front();
         e_user = exp_user.pop_front();
         assert (m_axis_tdata == e_data)
            else stop_on_error($sformatf("FAIL m_axis_tdata got %h expected %h (beat %0d)",
                                         m_axis_tdata, e_data, beat_count));
         assert (m_axis_tstrb == e_strb)
            else stop_on_error($sformatf("FAIL m_axis_tstrb got %h expected %h (beat %0d)",
                                         m_axis_tstrb, e_strb, beat_count));
         assert (m_axis_tlast == e_last)
            else stop_on_error($sformatf("FAIL m_axis_tlast got %h expected %h (beat %0d)",
                                         m_axis_tlast, e_last, beat_count));
         assert (m_axis_tuser == e_user)
            else stop_on_error($sformatf("FAIL m_axis_tuser got %h expected %h (beat %0d)",
                                         m_axis_tuser, e_user, beat_count));
      end
      beat_count++;   // Beats past the expected list still count
   endtask

   //////////////////////////////////////////////////
   // Random master stalls, about one cycle in four

   always @(negedge axi_aclk) begin
      if (axi_resetn) begin
         lfsr_state    = lfsr_step(lfsr_state);
         m_axis_tready = lfsr_state[0];
         lfsr_state    = lfsr_step(lfsr_state);
         m_axis_tready = m_axis_tready | lfsr_state[0];
      end
   end

   // Output monitor, samples before the edge updates
   always @(posedge axi_aclk) begin
      if (axi_resetn) begin
         assert (!m_axis_tvalid || tlast_sent)
            else stop_on_error("Master valid rose before the first packet was complete");
         if (held) begin
            assert (m_axis_tvalid)
               else stop_on_error("Master valid dropped while a beat was stalled");
            assert (m_axis_tdata == held_data)
               else stop_on_error($sformatf("FAIL m_axis_tdata was %h now %h under stall",
                                            held_data, m_axis_tdata));
            assert (m_axis_tstrb == held_strb)
               else stop_on_error($sformatf("FAIL m_axis_tstrb was %h now %h under stall",
                                            held_strb, m_axis_tstrb));
            assert (m_axis_tlast == held_last)
               else stop_on_error($sformatf("FAIL m_axis_tlast was %h now %h under stall",
                                            held_last, m_axis_tlast));
            assert (m_axis_tuser == held_user)
               else stop_on_error($sformatf("FAIL m_axis_tuser was %h now %h under stall",
                                            held_user, m_axis_tuser));
         end
         if (m_axis_tvalid && m_axis_tready) check_beat();
         if (s_axis_tvalid && s_axis_tready && s_axis_tlast) tlast_sent <= 1'b1;
         if (s_axis_tready) ready_was_high <= 1'b1;
         else if (ready_was_high) backpressure_seen <= 1'b1;
         held      <= m_axis_tvalid && !m_axis_tready;
         held_data <= m_axis_tdata;
         held_strb <= m_axis_tstrb;
         held_last <= m_axis_tlast;
         held_user <= m_axis_tuser;
      end
   end

   //////////////////////////////////////////////////
   // Main sequence

   initial begin : main
      axi_resetn    = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tstrb  = '0;
      s_axis_tlast  = 1'b0;
      s_axis_tvalid = 1'b0;
      m_axis_tready = 1'b0;
      for (int i = 0; i < 2*MAX_PKTS; i++) pkt_table[i] = '0;
      $readmemh("testbench/testdata_packets.txt", pkt_table);
      num_pkts = 0;
      while (num_pkts < MAX_PKTS && pkt_table[2*num_pkts] != 16'h0) num_pkts++;
      assert (num_pkts > 0) else stop_on_error("No packets were read from the data file");
      build_expected();
      loaded = 1'b1;

      repeat (2) @(posedge axi_aclk);   // Two cycles in reset
      @(negedge axi_aclk);
      axi_resetn = 1'b1;

      for (int p = 0; p < num_pkts; p++) send_packet(p);   // Back to back
      @(negedge axi_aclk);
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;

      wait (beat_count == total_beats);
      repeat (50) @(posedge axi_aclk);   // Room for stray extra beats

      assert (beat_count == total_beats)
         else stop_on_error($sformatf("FAIL beat count got %h expected %h",
                                      beat_count, total_beats));
      assert (backpressure_seen)
         else stop_on_error("Slave ready never went low under the full buffer load");
      $display("Verification passed");
      $finish;
   end

   // Watchdog, 40 cycles per expected beat plus slack
   initial begin : watchdog
      wait (loaded);
      repeat (total_beats * 40 + 1000) @(posedge axi_aclk);
      stop_on_error("Timeout before all expected beats came out");
   end

endmodule

// File: testbench/testdata_packets.txt
// Columns: packet byte length (hex, 1 to 640), first byte value (hex)
// Packet bytes count up from the first byte, modulo 256
0020 00
0040 a5
0005 10
0008 20
0010 30
0011 40
001f 50
0021 60
0640 f0
05dc 7e
0001 ff
0060 01
0100 80
003c 9a
0018 c3
0029 11
0400 22
0200 33
0007 44
0080 55
0123 66
0009 77
0038 88
02a0 99
